/* patch_pkg.sv */
package patch_pkg;

    localparam int SRAM_ADDR_W = 9;                          // 512 words
    localparam int SRAM_WORD_W = 64;
    localparam int SRAM_LANES  = 8;
    localparam int BYTE_W      = SRAM_WORD_W / SRAM_LANES;   // Width of one lane
    localparam int WB_W        = 32;

    // Request on the SRAM read/write port
    typedef struct packed {
        logic                   csb;    // Chip select, active low
        logic                   web;    // Write enable, active low
        logic [SRAM_ADDR_W-1:0] addr;
        logic [SRAM_WORD_W-1:0] din;
        logic [SRAM_LANES-1:0]  wmask;  // One bit per byte lane
    } sram_wr_t;

    // Data word of a bus write: one byte for one lane
    typedef struct packed {
        logic [17:0] rsvd_hi;
        logic [2:0]  lane;       // Bits [13:11]
        logic [2:0]  rsvd_mid;
        logic [7:0]  lane_byte;  // Bits [7:0]
    } wb_wr_view_t;

    // Data word of a bus read: half select only
    typedef struct packed {
        logic [19:0] rsvd_hi;
        logic        half;       // Bit 11
        logic [10:0] rsvd_lo;
    } wb_rd_view_t;

    // Same bus word, decoded by direction
    typedef union packed {
        wb_wr_view_t wr;
        wb_rd_view_t rd;
    } wb_cmd_u;

endpackage

/* sram_1rw1r.sv */
module sram_1rw1r #(
    parameter int DEPTH = 512
) (
    input  logic                               clk,
    input  patch_pkg::sram_wr_t                wr_i,
    input  logic                               csb1_i,   // Read port select, active low
    input  logic [patch_pkg::SRAM_ADDR_W-1:0]  addr1_i,
    output logic [patch_pkg::SRAM_WORD_W-1:0]  dout0_o,
    output logic [patch_pkg::SRAM_WORD_W-1:0]  dout1_o
);

    import patch_pkg::*;

    logic [SRAM_WORD_W-1:0] mem [DEPTH];

    logic wr_en;
    logic rd0_en;

    assign wr_en  = !wr_i.csb && !wr_i.web;
    assign rd0_en = !wr_i.csb && wr_i.web;

    // Byte-masked write on port 0
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < SRAM_LANES; i++) begin
                if (wr_i.wmask[i]) begin
                    mem[wr_i.addr][i*BYTE_W +: BYTE_W] <= wr_i.din[i*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // Port 0 read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd0_en) begin
            dout0_o <= mem[wr_i.addr];
        end
    end

    // Port 1 read sees the word from before a same-cycle write
    always_ff @(posedge clk) begin
        if (!csb1_i) begin
            dout1_o <= mem[addr1_i];
        end
    end

endmodule

/* wb_patch_port.sv */
module wb_patch_port #(
    parameter int WB_ADDRESS_OFFSET = 557,
    parameter int DATA_WIDTH        = 11,
    parameter int PATCH_SIZE        = 5
) (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               wbs_stb_i,
    input  logic                               wbs_cyc_i,
    input  logic                               wbs_we_i,
    input  logic [patch_pkg::WB_W-1:0]         wbs_adr_i,
    input  logic [patch_pkg::WB_W-1:0]         wbs_dat_i,
    input  logic [patch_pkg::SRAM_WORD_W-1:0]  rdata0_i,
    output patch_pkg::sram_wr_t                wr_o,
    output logic                               wbs_ack_o,
    output logic [patch_pkg::WB_W-1:0]         wbs_dat_o
);

    import patch_pkg::*;

    localparam int PW = DATA_WIDTH * PATCH_SIZE;

    wb_cmd_u         cmd;
    logic [WB_W-1:0] adr_off;
    logic [PW-1:0]   patch;
    logic            wb_req_active;
    logic            pending;     // Request taken, ack not yet given
    logic            rd_s1;       // Read data arrives from SRAM this cycle
    logic            half_s1;

    assign cmd     = wbs_dat_i;
    assign adr_off = wbs_adr_i - WB_W'(WB_ADDRESS_OFFSET);
    assign patch   = rdata0_i[PW-1:0];

    // No new request while an ack is outstanding
    assign wb_req_active = wbs_stb_i && wbs_cyc_i && !pending;

    always_comb begin
        wr_o.csb   = !wb_req_active;
        wr_o.web   = !wbs_we_i;
        wr_o.addr  = adr_off[SRAM_ADDR_W-1:0];
        wr_o.din   = SRAM_WORD_W'(cmd.wr.lane_byte) << (cmd.wr.lane * BYTE_W);
        wr_o.wmask = wbs_we_i ? (SRAM_LANES'(1) << cmd.wr.lane) : '0;  // One-hot lane
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending   <= 1'b0;
            rd_s1     <= 1'b0;
            wbs_ack_o <= 1'b0;
        end else begin
            rd_s1     <= wb_req_active && !wbs_we_i;
            wbs_ack_o <= (wb_req_active && wbs_we_i) || rd_s1;  // Write T+1, read T+2
            if (wb_req_active) begin
                pending <= 1'b1;
            end else if (wbs_ack_o) begin
                pending <= 1'b0;
            end
        end
    end

    // Half select travels with the read
    always_ff @(posedge clk) begin
        if (wb_req_active && !wbs_we_i) begin
            half_s1 <= cmd.rd.half;
        end
    end

    // Capture the selected half, valid during ack
    always_ff @(posedge clk) begin
        if (rd_s1) begin
            if (half_s1) begin
                wbs_dat_o <= WB_W'(patch >> WB_W);  // Upper bits, zero-extended
            end else begin
                wbs_dat_o <= patch[WB_W-1:0];
            end
        end
    end

endmodule

/* query_patch_mem.sv */
module query_patch_mem #(
    parameter int DATA_WIDTH        = 11,
    parameter int PATCH_SIZE        = 5,
    parameter int DEPTH             = 512,
    parameter int WB_ADDRESS_OFFSET = 557
) (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               wb_mode_i,
    input  logic                               patch_csb_i,
    input  logic                               patch_web_i,
    input  logic [patch_pkg::SRAM_ADDR_W-1:0]  patch_addr_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0]   patch_wdata_i,
    output logic [DATA_WIDTH*PATCH_SIZE-1:0]   patch_rdata_o,
    input  logic                               csb1_i,
    input  logic [patch_pkg::SRAM_ADDR_W-1:0]  addr1_i,
    output logic [DATA_WIDTH*PATCH_SIZE-1:0]   rpatch1_o,
    input  logic                               wbs_stb_i,
    input  logic                               wbs_cyc_i,
    input  logic                               wbs_we_i,
    input  logic [patch_pkg::WB_W-1:0]         wbs_adr_i,
    input  logic [patch_pkg::WB_W-1:0]         wbs_dat_i,
    output logic                               wbs_ack_o,
    output logic [patch_pkg::WB_W-1:0]         wbs_dat_o
);

    import patch_pkg::*;

    localparam int PW = DATA_WIDTH * PATCH_SIZE;

    sram_wr_t               stream_wr;
    sram_wr_t               wb_wr;
    sram_wr_t               ram_wr;
    logic                   wb_stb;
    logic [SRAM_WORD_W-1:0] rdata0;
    logic [SRAM_WORD_W-1:0] rdata1;

    // Streaming side always writes whole patches
    always_comb begin
        stream_wr.csb   = patch_csb_i;
        stream_wr.web   = patch_web_i;
        stream_wr.addr  = patch_addr_i;
        stream_wr.din   = SRAM_WORD_W'(patch_wdata_i);
        stream_wr.wmask = '1;
    end

    assign wb_stb = wbs_stb_i && wb_mode_i;  // Bus is deaf outside Wishbone mode
    assign ram_wr = wb_mode_i ? wb_wr : stream_wr;

    wb_patch_port #(
        .WB_ADDRESS_OFFSET (WB_ADDRESS_OFFSET),
        .DATA_WIDTH        (DATA_WIDTH),
        .PATCH_SIZE        (PATCH_SIZE)
    ) wb_patch_port_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wbs_stb_i (wb_stb),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .rdata0_i  (rdata0),
        .wr_o      (wb_wr),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o)
    );

    sram_1rw1r #(
        .DEPTH (DEPTH)
    ) sram_inst (
        .clk     (clk),
        .wr_i    (ram_wr),
        .csb1_i  (csb1_i),
        .addr1_i (addr1_i),
        .dout0_o (rdata0),
        .dout1_o (rdata1)
    );

    // Drop the padding above the patch
    assign patch_rdata_o = rdata0[PW-1:0];
    assign rpatch1_o     = rdata1[PW-1:0];

endmodule

/* patch_sad.sv */
module patch_sad #(
    parameter int DATA_WIDTH = 11,
    parameter int PATCH_SIZE = 5
) (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               sad_req_i,
    input  logic [patch_pkg::SRAM_ADDR_W-1:0]  sad_addr_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0]   sad_patch_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0]   rpatch1_i,
    output logic                               csb1_o,
    output logic [patch_pkg::SRAM_ADDR_W-1:0]  addr1_o,
    output logic                               sad_valid_o,
    output logic [DATA_WIDTH+2:0]              sad_o
);

    localparam int PW    = DATA_WIDTH * PATCH_SIZE;
    localparam int SAD_W = DATA_WIDTH + 3;

    logic [PW-1:0]    req_patch_q;  // Request patch, aligned with SRAM data
    logic             vld_q1;
    logic [SAD_W-1:0] sad_sum;

    function automatic logic [DATA_WIDTH-1:0] abs_diff(
        input logic [DATA_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] b
    );
        return (a > b) ? (a - b) : (b - a);
    endfunction

    // Stage 0 issues the port-1 read directly
    assign csb1_o  = !sad_req_i;
    assign addr1_o = sad_addr_i;

    always_ff @(posedge clk) begin
        if (sad_req_i) begin
            req_patch_q <= sad_patch_i;
        end
    end

    always_comb begin
        sad_sum = '0;
        for (int i = 0; i < PATCH_SIZE; i++) begin
            sad_sum = sad_sum + SAD_W'(abs_diff(rpatch1_i[i*DATA_WIDTH +: DATA_WIDTH],
                                                req_patch_q[i*DATA_WIDTH +: DATA_WIDTH]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld_q1      <= 1'b0;
            sad_valid_o <= 1'b0;
        end else begin
            vld_q1      <= sad_req_i;
            sad_valid_o <= vld_q1;  // Two cycles after the request
        end
    end

    always_ff @(posedge clk) begin
        if (vld_q1) begin
            sad_o <= sad_sum;
        end
    end

endmodule

/* query_patch_top.sv */
module query_patch_top #(
    parameter int DATA_WIDTH        = 11,
    parameter int PATCH_SIZE        = 5,
    parameter int DEPTH             = 512,
    parameter int WB_ADDRESS_OFFSET = 557
) (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               patch_csb_i,
    input  logic                               patch_web_i,
    input  logic [patch_pkg::SRAM_ADDR_W-1:0]  patch_addr_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0]   patch_wdata_i,
    output logic [DATA_WIDTH*PATCH_SIZE-1:0]   patch_rdata_o,
    input  logic                               wb_mode_i,
    input  logic                               wbs_stb_i,
    input  logic                               wbs_cyc_i,
    input  logic                               wbs_we_i,
    input  logic [patch_pkg::WB_W-1:0]         wbs_adr_i,
    input  logic [patch_pkg::WB_W-1:0]         wbs_dat_i,
    output logic                               wbs_ack_o,
    output logic [patch_pkg::WB_W-1:0]         wbs_dat_o,
    input  logic                               sad_req_i,
    input  logic [patch_pkg::SRAM_ADDR_W-1:0]  sad_addr_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0]   sad_patch_i,
    output logic                               sad_valid_o,
    output logic [DATA_WIDTH+2:0]              sad_o
);

    import patch_pkg::*;

    logic                             sad_csb1;
    logic [SRAM_ADDR_W-1:0]           sad_addr1;
    logic [DATA_WIDTH*PATCH_SIZE-1:0] rpatch1;   // Stored patch for the matcher

    query_patch_mem #(
        .DATA_WIDTH        (DATA_WIDTH),
        .PATCH_SIZE        (PATCH_SIZE),
        .DEPTH             (DEPTH),
        .WB_ADDRESS_OFFSET (WB_ADDRESS_OFFSET)
    ) query_patch_mem_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .wb_mode_i     (wb_mode_i),
        .patch_csb_i   (patch_csb_i),
        .patch_web_i   (patch_web_i),
        .patch_addr_i  (patch_addr_i),
        .patch_wdata_i (patch_wdata_i),
        .patch_rdata_o (patch_rdata_o),
        .csb1_i        (sad_csb1),
        .addr1_i       (sad_addr1),
        .rpatch1_o     (rpatch1),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_cyc_i     (wbs_cyc_i),
        .wbs_we_i      (wbs_we_i),
        .wbs_adr_i     (wbs_adr_i),
        .wbs_dat_i     (wbs_dat_i),
        .wbs_ack_o     (wbs_ack_o),
        .wbs_dat_o     (wbs_dat_o)
    );

    patch_sad #(
        .DATA_WIDTH (DATA_WIDTH),
        .PATCH_SIZE (PATCH_SIZE)
    ) patch_sad_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .sad_req_i   (sad_req_i),
        .sad_addr_i  (sad_addr_i),
        .sad_patch_i (sad_patch_i),
        .rpatch1_i   (rpatch1),
        .csb1_o      (sad_csb1),
        .addr1_o     (sad_addr1),
        .sad_valid_o (sad_valid_o),
        .sad_o       (sad_o)
    );

endmodule

/* query_patch_properties.sv */
module query_patch_properties #(
    parameter bit HAS_ACK = 1'b1,  // Instance watches the Wishbone ack
    parameter bit HAS_SAD = 1'b1   // Instance watches the matcher
) (
    input logic clk,
    input logic rst_n_i,
    input logic ack_i,
    input logic req_i,
    input logic valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    if (HAS_ACK) begin : g_ack
        // Registered ack leaves reset idle
        ack_reset_idle: assert property (@(posedge clk) !rst_n_i |=> !ack_i)
            else begin
                $error("Ack high right after reset");
                fail_count++;
            end

        ack_single: assert property (@(posedge clk) disable iff (!rst_n_i) ack_i |=> !ack_i)
            else begin
                $error("Ack held high for two cycles");
                fail_count++;
            end
    end

    if (HAS_SAD) begin : g_sad
        sad_reset_idle: assert property (@(posedge clk) !rst_n_i |=> !valid_i)
            else begin
                $error("SAD valid high right after reset");
                fail_count++;
            end

        // Matcher latency is fixed at two cycles
        valid_latency: assert property (
            @(posedge clk) disable iff (!rst_n_i) valid_i == $past(req_i, 2))
            else begin
                $error("SAD valid does not follow the request by two cycles");
                fail_count++;
            end
    end

endmodule

bind query_patch_mem query_patch_properties #(
    .HAS_ACK (1'b1),
    .HAS_SAD (1'b0)
) mem_props_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .ack_i   (wbs_ack_o),
    .req_i   (1'b0),
    .valid_i (1'b0)
);

bind patch_sad query_patch_properties #(
    .HAS_ACK (1'b0),
    .HAS_SAD (1'b1)
) sad_props_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .ack_i   (1'b0),
    .req_i   (sad_req_i),
    .valid_i (sad_valid_o)
);

/* query_patch_checker.sv */
module query_patch_checker #(
    parameter int PW    = 55,
    parameter int SAD_W = 14
) (
    input logic             clk,
    input logic             rst_n_i,
    input logic             wb_mode_i,
    input logic             patch_csb_i,
    input logic             patch_web_i,
    input logic [PW-1:0]    patch_rdata_i,
    input logic             wbs_stb_i,
    input logic             wbs_cyc_i,
    input logic             wbs_we_i,
    input logic             wbs_ack_i,
    input logic [31:0]      wb_rdata_i,
    input logic             sad_req_i,
    input logic             sad_valid_i,
    input logic [SAD_W-1:0] sad_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int               error_count = 0;
    int               cyc = 0;
    logic [PW-1:0]    stream_exp [$];
    logic [31:0]      wb_exp [$];
    logic [SAD_W-1:0] sad_exp [$];
    logic             stream_due;
    logic             wb_out;        // Bus request accepted, ack still owed
    logic             wb_rd;
    int               wb_due;
    logic             sad_d1;
    logic             sad_d2;
    logic             accept;

    function void expect_stream(input logic [PW-1:0] v);
        stream_exp.push_back(v);
    endfunction

    function void expect_wb(input logic [31:0] v);
        wb_exp.push_back(v);
    endfunction

    function void expect_sad(input logic [SAD_W-1:0] v);
        sad_exp.push_back(v);
    endfunction

    function int pending();
        return stream_exp.size() + wb_exp.size() + sad_exp.size();
    endfunction

    task automatic report_value(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp);
        error_count++;
    endtask

    // Sample mid-cycle, when every DUT signal is settled
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (!rst_n_i) begin
            stream_due = 1'b0;
            wb_out     = 1'b0;
            sad_d1     = 1'b0;
            sad_d2     = 1'b0;
        end else begin
            if (stream_due) begin
                if (stream_exp.size() == 0) begin
                    $display("Streaming read data arrived with nothing expected at %0t", $time);
                    error_count++;
                end else begin
                    if (patch_rdata_i !== stream_exp[0]) begin
                        report_value("streaming read", 64'(patch_rdata_i), 64'(stream_exp[0]));
                    end
                    void'(stream_exp.pop_front());
                end
            end
            stream_due = !wb_mode_i && !patch_csb_i && patch_web_i;

            accept = wb_mode_i && wbs_stb_i && wbs_cyc_i && !wb_out;
            if (wbs_ack_i) begin
                if (!wb_out) begin
                    report_value("Wishbone ack without a request", 64'(1), 64'(0));
                end else if (cyc != wb_due) begin
                    report_value("Wishbone ack cycle", 64'(cyc), 64'(wb_due));
                end
                if (wb_out && wb_rd) begin
                    if (wb_exp.size() == 0) begin
                        $display("Wishbone read data with nothing expected at %0t", $time);
                        error_count++;
                    end else begin
                        if (wb_rdata_i !== wb_exp[0]) begin
                            report_value("Wishbone read", 64'(wb_rdata_i), 64'(wb_exp[0]));
                        end
                        void'(wb_exp.pop_front());
                    end
                end
                wb_out = 1'b0;
            end else if (wb_out && cyc > wb_due) begin
                report_value("Wishbone ack missing, cycle", 64'(cyc), 64'(wb_due));
                wb_out = 1'b0;
            end
            if (accept) begin
                wb_out = 1'b1;
                wb_rd  = !wbs_we_i;
                wb_due = cyc + (wbs_we_i ? 1 : 2);  // Write acks one cycle on, read two
            end

            if (sad_valid_i !== sad_d2) begin
                report_value("sad_valid_o", 64'(sad_valid_i), 64'(sad_d2));
            end
            if (sad_d2) begin
                if (sad_exp.size() == 0) begin
                    $display("SAD result arrived with nothing expected at %0t", $time);
                    error_count++;
                end else begin
                    if (sad_valid_i === 1'b1 && sad_i !== sad_exp[0]) begin
                        report_value("SAD", 64'(sad_i), 64'(sad_exp[0]));
                    end
                    void'(sad_exp.pop_front());
                end
            end
            sad_d2 = sad_d1;
            sad_d1 = sad_req_i;
        end
    end

endmodule

/* tb_query_patch.sv */
module tb_query_patch;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW          = 11;
    localparam int PS          = 5;
    localparam int PW          = DW * PS;
    localparam int SAD_W       = DW + 3;
    localparam int WB_OFFSET   = 557;
    localparam int ACK_TIMEOUT = 20;

    logic             clk;
    logic             rst_n;
    logic             patch_csb;
    logic             patch_web;
    logic [8:0]       patch_addr;
    logic [PW-1:0]    patch_wdata;
    logic [PW-1:0]    patch_rdata;
    logic             wb_mode;
    logic             wbs_stb;
    logic             wbs_cyc;
    logic             wbs_we;
    logic [31:0]      wbs_adr;
    logic [31:0]      wbs_dat_w;
    logic             wbs_ack;
    logic [31:0]      wbs_dat_r;
    logic             sad_req;
    logic [8:0]       sad_addr;
    logic [PW-1:0]    sad_patch;
    logic             sad_valid;
    logic [SAD_W-1:0] sad_res;

    logic [63:0] shadow [512];   // Expected SRAM contents
    int          used [$];       // Addresses holding a known patch
    int          timeout_count = 0;
    int          assert_fails;

    query_patch_top #(
        .DATA_WIDTH        (DW),
        .PATCH_SIZE        (PS),
        .DEPTH             (512),
        .WB_ADDRESS_OFFSET (WB_OFFSET)
    ) query_patch_top_inst (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .patch_csb_i   (patch_csb),
        .patch_web_i   (patch_web),
        .patch_addr_i  (patch_addr),
        .patch_wdata_i (patch_wdata),
        .patch_rdata_o (patch_rdata),
        .wb_mode_i     (wb_mode),
        .wbs_stb_i     (wbs_stb),
        .wbs_cyc_i     (wbs_cyc),
        .wbs_we_i      (wbs_we),
        .wbs_adr_i     (wbs_adr),
        .wbs_dat_i     (wbs_dat_w),
        .wbs_ack_o     (wbs_ack),
        .wbs_dat_o     (wbs_dat_r),
        .sad_req_i     (sad_req),
        .sad_addr_i    (sad_addr),
        .sad_patch_i   (sad_patch),
        .sad_valid_o   (sad_valid),
        .sad_o         (sad_res)
    );

    query_patch_checker #(
        .PW    (PW),
        .SAD_W (SAD_W)
    ) query_patch_checker_inst (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .wb_mode_i     (wb_mode),
        .patch_csb_i   (patch_csb),
        .patch_web_i   (patch_web),
        .patch_rdata_i (patch_rdata),
        .wbs_stb_i     (wbs_stb),
        .wbs_cyc_i     (wbs_cyc),
        .wbs_we_i      (wbs_we),
        .wbs_ack_i     (wbs_ack),
        .wb_rdata_i    (wbs_dat_r),
        .sad_req_i     (sad_req),
        .sad_valid_i   (sad_valid),
        .sad_i         (sad_res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [PW-1:0] rand_patch();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[PW-1:0];
    endfunction

    // One byte lane replaced, the rest kept
    function automatic logic [63:0] lane_merge(input logic [63:0] word, input int lane,
                                               input logic [7:0] b);
        logic [63:0] w;
        w = word;
        w[lane*8 +: 8] = b;
        return w;
    endfunction

    function automatic logic [31:0] half_select(input logic [PW-1:0] p, input logic half);
        logic [63:0] wide;
        wide = 64'(p);
        return half ? wide[63:32] : wide[31:0];
    endfunction

    function automatic int sad_ref(input logic [PW-1:0] a, input logic [PW-1:0] b);
        int s;
        int pa;
        int pb;
        s = 0;
        for (int i = 0; i < PS; i++) begin
            pa = a[i*DW +: DW];
            pb = b[i*DW +: DW];
            s += (pa > pb) ? pa - pb : pb - pa;
        end
        return s;
    endfunction

    task automatic stream_write(input int addr, input logic [PW-1:0] data);
        @(posedge clk);
        patch_csb   <= 1'b0;
        patch_web   <= 1'b0;
        patch_addr  <= 9'(addr);
        patch_wdata <= data;
        @(posedge clk);
        patch_csb <= 1'b1;
        patch_web <= 1'b1;
    endtask

    task automatic stream_read(input int addr);
        query_patch_checker_inst.expect_stream(shadow[addr][PW-1:0]);
        @(posedge clk);
        patch_csb  <= 1'b0;
        patch_web  <= 1'b1;
        patch_addr <= 9'(addr);
        @(posedge clk);
        patch_csb <= 1'b1;
    endtask

    // Hold the strobe until ack, as a classic bus master
    task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat);
        logic got;
        got = 1'b0;
        @(posedge clk);
        wbs_stb   <= 1'b1;
        wbs_cyc   <= 1'b1;
        wbs_we    <= we;
        wbs_adr   <= adr;
        wbs_dat_w <= dat;
        for (int i = 0; i < ACK_TIMEOUT && !got; i++) begin
            @(posedge clk);
            got = wbs_ack;
        end
        wbs_stb <= 1'b0;
        wbs_cyc <= 1'b0;
        wbs_we  <= 1'b0;
        if (!got) begin
            $display("Timeout: no Wishbone ack for address %h at %0t", adr, $time);
            timeout_count++;
        end
    endtask

    task automatic drain_checks();
        int n;
        n = 0;
        while (query_patch_checker_inst.pending() != 0 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (n >= 50) begin
            $display("Timeout: expected results never arrived from the DUT");
            timeout_count++;
        end
    endtask

    initial begin
        int            a;
        logic [PW-1:0] p;
        logic [2:0]    lane;
        logic [7:0]    b;
        logic          h;
        logic [31:0]   dat;

        void'($urandom(32'h0a21b111));
        rst_n       = 1'b0;
        patch_csb   = 1'b1;
        patch_web   = 1'b1;
        patch_addr  = '0;
        patch_wdata = '0;
        wb_mode     = 1'b0;
        wbs_stb     = 1'b0;
        wbs_cyc     = 1'b0;
        wbs_we      = 1'b0;
        wbs_adr     = '0;
        wbs_dat_w   = '0;
        sad_req     = 1'b0;
        sad_addr    = '0;
        sad_patch   = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Whole patches through the streaming port
        for (int i = 0; i < 16; i++) begin
            a = $urandom % 512;
            p = rand_patch();
            stream_write(a, p);
            shadow[a] = 64'(p);
            used.push_back(a);
        end
        foreach (used[i]) stream_read(used[i]);

        @(posedge clk);
        wb_mode <= 1'b1;
        for (int i = 0; i < 12; i++) begin
            a    = used[$urandom % used.size()];
            lane = 3'($urandom);
            b    = 8'($urandom);
            dat  = ($urandom & ~32'h0000_38ff) | (32'(lane) << 11) | 32'(b);  // Noise in spares
            wb_access(1'b1, 32'(a + WB_OFFSET), dat);
            shadow[a] = lane_merge(shadow[a], lane, b);
        end
        for (int i = 0; i < 12; i++) begin
            a   = used[$urandom % used.size()];
            h   = 1'($urandom);
            dat = ($urandom & ~32'h0000_0800) | (32'(h) << 11);
            query_patch_checker_inst.expect_wb(half_select(shadow[a][PW-1:0], h));
            wb_access(1'b0, 32'(a + WB_OFFSET), dat);
        end

        // Each port is locked out in the other mode
        stream_write(used[0], rand_patch());
        @(posedge clk);
        wb_mode   <= 1'b0;
        wbs_stb   <= 1'b1;
        wbs_cyc   <= 1'b1;
        wbs_we    <= 1'b1;
        wbs_adr   <= 32'(used[1] + WB_OFFSET);
        wbs_dat_w <= 32'h0000_38a5;
        repeat (4) @(posedge clk);
        wbs_stb <= 1'b0;
        wbs_cyc <= 1'b0;
        wbs_we  <= 1'b0;
        foreach (used[i]) stream_read(used[i]);

        // Back-to-back matcher requests
        for (int i = 0; i < 24; i++) begin
            a = used[$urandom % used.size()];
            p = rand_patch();
            query_patch_checker_inst.expect_sad(SAD_W'(sad_ref(shadow[a][PW-1:0], p)));
            @(posedge clk);
            sad_req   <= 1'b1;
            sad_addr  <= 9'(a);
            sad_patch <= p;
        end
        @(posedge clk);
        sad_req <= 1'b0;

        drain_checks();
        repeat (2) @(posedge clk);
        assert_fails = query_patch_top_inst.query_patch_mem_inst.mem_props_inst.fail_count
                     + query_patch_top_inst.patch_sad_inst.sad_props_inst.fail_count;
        $display("Checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
                 query_patch_checker_inst.error_count, timeout_count, assert_fails);
        if (query_patch_checker_inst.error_count == 0 && timeout_count == 0
                && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
patch_pkg.sv
sram_1rw1r.sv
wb_patch_port.sv
query_patch_mem.sv
patch_sad.sv
query_patch_top.sv
query_patch_properties.sv
query_patch_checker.sv
tb_query_patch.sv
